// ==== Makefile ====
TOP = arp_top_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+src
src/net_pkg.sv
src/arp_pkg.sv
src/arp_if.sv
src/arp_cache.sv
src/arp_rx_handler.sv
src/arp_resolver.sv
src/arp_tx_queue.sv
src/arp_top.sv
tb/arp_top_tb.sv

// ==== src/arp_cache.sv ====
`timescale 1ns/1ps
`include "arp_defines.svh"

module arp_cache (
    input  logic               clk,
    input  logic               rst,
    cache_query_if.responder   query,
    input  logic               wr_valid,
    input  net_pkg::ip_addr_t  wr_ip,
    input  net_pkg::mac_addr_t wr_mac,
    input  logic               clear_cache
);
    localparam int ENTRIES = `ARP_CACHE_ENTRIES;
    localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    logic [ENTRIES-1:0] entry_valid;
    net_pkg::ip_addr_t  entry_ip [ENTRIES];
    net_pkg::mac_addr_t entry_mac [ENTRIES];
    logic [IDX_W-1:0]   rr_ptr;

    logic               q_hit;
    net_pkg::mac_addr_t q_mac;
    logic               wr_hit;
    logic [IDX_W-1:0]   wr_hit_idx;
    logic [IDX_W-1:0]   wr_idx;

    // fully associative compare, for the query and for the write port
    always_comb begin
        q_hit = 1'b0;
        q_mac = '0;
        wr_hit = 1'b0;
        wr_hit_idx = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (entry_valid[i] && entry_ip[i] == query.query_ip) begin
                q_hit = 1'b1;
                q_mac = entry_mac[i];
            end
            if (entry_valid[i] && entry_ip[i] == wr_ip) begin
                wr_hit = 1'b1;
                wr_hit_idx = IDX_W'(i);
            end
        end
    end

    // refresh a known address in place, else take the next slot
    assign wr_idx = wr_hit ? wr_hit_idx : rr_ptr;

    always_ff @(posedge clk) begin
        if (rst || clear_cache) begin
            entry_valid <= '0;
            rr_ptr <= '0;
        end else if (wr_valid) begin
            entry_valid[wr_idx] <= 1'b1;
            if (!wr_hit) begin
                rr_ptr <= (rr_ptr == IDX_W'(ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            entry_ip[wr_idx] <= wr_ip;
            entry_mac[wr_idx] <= wr_mac;
        end
    end

    // registered answer
    always_ff @(posedge clk) begin
        if (rst) begin
            query.resp_valid <= 1'b0;
        end else begin
            query.resp_valid <= query.query_valid;
        end
    end

    always_ff @(posedge clk) begin
        query.resp_hit <= q_hit;
        query.resp_mac <= q_mac;
    end

endmodule

// ==== src/arp_defines.svh ====
`ifndef ARP_DEFINES_SVH
`define ARP_DEFINES_SVH

// cache geometry
`define ARP_CACHE_ENTRIES 4

// request frames sent per lookup, first one included
`define ARP_RETRY_COUNT 4

// cycles between request frames, then wait after the last one
`define ARP_RETRY_INTERVAL 64
`define ARP_REQUEST_TIMEOUT 256

// fixed field values for ARP over Ethernet with IPv4
`define ARP_ETHERTYPE 16'h0806
`define ARP_HTYPE_ETH 16'h0001
`define ARP_PTYPE_IPV4 16'h0800

`endif

// ==== src/arp_if.sv ====
`timescale 1ns/1ps

// cache lookup, answered one cycle after the query
interface cache_query_if;
    logic               query_valid;
    net_pkg::ip_addr_t  query_ip;
    logic               resp_valid;
    logic               resp_hit;
    net_pkg::mac_addr_t resp_mac;

    modport requester (output query_valid, output query_ip,
                       input resp_valid, input resp_hit, input resp_mac);
    modport responder (input query_valid, input query_ip,
                       output resp_valid, output resp_hit, output resp_mac);
endinterface

// outgoing frame request, fields held until accept
interface tx_req_if;
    logic               valid;
    net_pkg::mac_addr_t dest_mac;
    arp_pkg::arp_oper_t oper;
    net_pkg::mac_addr_t tha;
    net_pkg::ip_addr_t  tpa;
    logic               accept;

    modport source (output valid, output dest_mac, output oper, output tha, output tpa,
                    input accept);
    modport sink (input valid, input dest_mac, input oper, input tha, input tpa,
                  output accept);
endinterface

// ==== src/arp_pkg.sv ====
package arp_pkg;

    // operation codes on the wire
    typedef enum logic [15:0] {
        ARP_REQUEST = 16'd1,
        ARP_REPLY   = 16'd2
    } arp_oper_t;

    // parsed frame, ethernet header followed by the ARP body
    typedef struct packed {
        net_pkg::mac_addr_t eth_dest_mac;
        net_pkg::mac_addr_t eth_src_mac;
        logic [15:0]        eth_type;
        logic [15:0]        htype;
        logic [15:0]        ptype;
        arp_oper_t          oper;
        net_pkg::mac_addr_t sha;
        net_pkg::ip_addr_t  spa;
        net_pkg::mac_addr_t tha;
        net_pkg::ip_addr_t  tpa;
    } arp_frame_t;

endpackage

// ==== src/arp_resolver.sv ====
`timescale 1ns/1ps
`include "arp_defines.svh"

module arp_resolver (
    input  logic               clk,
    input  logic               rst,
    input  logic               request_valid,
    input  net_pkg::ip_addr_t  request_ip,
    output logic               response_valid,
    output logic               response_error,
    output net_pkg::mac_addr_t response_mac,
    input  net_pkg::ip_addr_t  gateway_ip,
    input  net_pkg::ip_addr_t  subnet_mask,
    cache_query_if.requester   query,
    tx_req_if.source           tx
);
    localparam int TIMER_MAX = (`ARP_REQUEST_TIMEOUT > `ARP_RETRY_INTERVAL) ?
                               `ARP_REQUEST_TIMEOUT : `ARP_RETRY_INTERVAL;
    localparam int TIMER_W = $clog2(TIMER_MAX + 1);
    localparam int RETRY_W = $clog2(`ARP_RETRY_COUNT + 1);
    localparam logic [TIMER_W-1:0] INTERVAL_LOAD = TIMER_W'(`ARP_RETRY_INTERVAL - 1);
    localparam logic [TIMER_W-1:0] TIMEOUT_LOAD = TIMER_W'(`ARP_REQUEST_TIMEOUT - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_CHECK,
        S_ARPING
    } state_t;

    state_t             state;
    net_pkg::ip_addr_t  target_ip;
    logic               bcast_q;
    logic               error_q;
    logic               tx_pending;
    logic [RETRY_W-1:0] retries_left;
    logic [TIMER_W-1:0] timer;

    logic busy;
    logic take;
    logic is_bcast;
    logic is_local;
    logic hit;

    assign busy = (state != S_IDLE) || tx_pending;
    assign take = request_valid && !busy;

    // host bits all set means subnet broadcast
    assign is_bcast = (~(request_ip | subnet_mask)) == 32'd0;
    assign is_local = ((request_ip ^ gateway_ip) & subnet_mask) == 32'd0;

    assign query.query_valid = (state == S_LOOKUP) || (state == S_ARPING);
    assign query.query_ip = target_ip;
    assign hit = query.resp_valid && query.resp_hit &&
                 ((state == S_CHECK) || (state == S_ARPING));

    assign response_valid = bcast_q || error_q || hit;
    assign response_error = error_q;
    assign response_mac = bcast_q ? '1 : query.resp_mac;

    // broadcast who-has for the target
    assign tx.valid = tx_pending;
    assign tx.dest_mac = '1;
    assign tx.oper = arp_pkg::ARP_REQUEST;
    assign tx.tha = '0;
    assign tx.tpa = target_ip;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            bcast_q <= 1'b0;
            error_q <= 1'b0;
            tx_pending <= 1'b0;
            retries_left <= '0;
            timer <= '0;
        end else begin
            bcast_q <= 1'b0;
            error_q <= 1'b0;
            if (tx.accept) begin
                tx_pending <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (take) begin
                        if (is_bcast) begin
                            bcast_q <= 1'b1;
                        end else begin
                            state <= S_LOOKUP;
                        end
                    end
                end
                S_LOOKUP: begin
                    state <= S_CHECK;
                end
                S_CHECK: begin
                    if (hit) begin
                        state <= S_IDLE;
                    end else begin
                        // miss, first request goes out now
                        state <= S_ARPING;
                        tx_pending <= 1'b1;
                        retries_left <= RETRY_W'(`ARP_RETRY_COUNT - 1);
                        timer <= (`ARP_RETRY_COUNT > 1) ? INTERVAL_LOAD : TIMEOUT_LOAD;
                    end
                end
                S_ARPING: begin
                    if (hit) begin
                        state <= S_IDLE;
                    end else if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else if (retries_left != '0) begin
                        // a frame still waiting in the queue counts as sent
                        tx_pending <= 1'b1;
                        retries_left <= retries_left - 1'b1;
                        timer <= (retries_left > RETRY_W'(1)) ? INTERVAL_LOAD : TIMEOUT_LOAD;
                    end else begin
                        error_q <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // off-subnet addresses resolve through the gateway
    always_ff @(posedge clk) begin
        if (take) begin
            target_ip <= is_local ? request_ip : gateway_ip;
        end
    end

endmodule

// ==== src/arp_rx_handler.sv ====
`timescale 1ns/1ps
`include "arp_defines.svh"

module arp_rx_handler (
    input  logic                clk,
    input  logic                rst,
    input  arp_pkg::arp_frame_t frame,
    input  logic                frame_valid,
    output logic                frame_ready,
    input  net_pkg::mac_addr_t  local_mac,
    input  net_pkg::ip_addr_t   local_ip,
    output logic                wr_valid,
    output net_pkg::ip_addr_t   wr_ip,
    output net_pkg::mac_addr_t  wr_mac,
    tx_req_if.source            tx
);
    logic well_formed;
    logic from_self;
    logic learnable;
    logic needs_reply;
    logic learned;

    assign well_formed = (frame.eth_type == `ARP_ETHERTYPE) &&
                         (frame.htype == `ARP_HTYPE_ETH) &&
                         (frame.ptype == `ARP_PTYPE_IPV4);

    // our own frames looped back are neither learned nor answered
    assign from_self = (frame.sha == local_mac);
    assign learnable = well_formed && !from_self;
    assign needs_reply = learnable && (frame.oper == arp_pkg::ARP_REQUEST) &&
                         (frame.tpa == local_ip);

    // reply goes straight back to the asker
    assign tx.valid = frame_valid && learned && needs_reply;
    assign tx.dest_mac = frame.eth_src_mac;
    assign tx.oper = arp_pkg::ARP_REPLY;
    assign tx.tha = frame.sha;
    assign tx.tpa = frame.spa;

    // hold a good frame until its sender is in the cache
    always_comb begin
        if (!learnable) begin
            frame_ready = frame_valid;
        end else if (!learned) begin
            frame_ready = 1'b0;
        end else if (needs_reply) begin
            frame_ready = tx.accept;
        end else begin
            frame_ready = frame_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            learned <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= frame_valid && learnable && !learned;
            if (frame_valid && frame_ready) begin
                learned <= 1'b0;
            end else if (frame_valid && learnable) begin
                learned <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_ip <= frame.spa;
        wr_mac <= frame.sha;
    end

endmodule

// ==== src/arp_top.sv ====
`timescale 1ns/1ps
`include "arp_defines.svh"

module arp_top (
    input  logic               clk,
    input  logic               rst,

    // incoming parsed frame
    input  logic               in_valid,
    output logic               in_ready,
    input  net_pkg::mac_addr_t in_eth_src_mac,
    input  logic [15:0]        in_eth_type,
    input  logic [15:0]        in_htype,
    input  logic [15:0]        in_ptype,
    input  logic [15:0]        in_oper,
    input  net_pkg::mac_addr_t in_sha,
    input  net_pkg::ip_addr_t  in_spa,
    input  net_pkg::mac_addr_t in_tha,
    input  net_pkg::ip_addr_t  in_tpa,

    // outgoing parsed frame
    output logic               out_valid,
    input  logic               out_ready,
    output net_pkg::mac_addr_t out_eth_dest_mac,
    output net_pkg::mac_addr_t out_eth_src_mac,
    output logic [15:0]        out_eth_type,
    output logic [15:0]        out_htype,
    output logic [15:0]        out_ptype,
    output logic [15:0]        out_oper,
    output net_pkg::mac_addr_t out_sha,
    output net_pkg::ip_addr_t  out_spa,
    output net_pkg::mac_addr_t out_tha,
    output net_pkg::ip_addr_t  out_tpa,

    // host lookups
    input  logic               request_valid,
    input  net_pkg::ip_addr_t  request_ip,
    output logic               response_valid,
    output logic               response_error,
    output net_pkg::mac_addr_t response_mac,

    // configuration
    input  net_pkg::mac_addr_t local_mac,
    input  net_pkg::ip_addr_t  local_ip,
    input  net_pkg::ip_addr_t  gateway_ip,
    input  net_pkg::ip_addr_t  subnet_mask,
    input  logic               clear_cache
);
    arp_pkg::arp_frame_t in_frame;
    arp_pkg::arp_frame_t out_frame;

    logic               wr_valid;
    net_pkg::ip_addr_t  wr_ip;
    net_pkg::mac_addr_t wr_mac;

    net_pkg::mac_addr_t q_dest_mac;
    arp_pkg::arp_oper_t q_oper;
    net_pkg::mac_addr_t q_tha;
    net_pkg::ip_addr_t  q_tpa;

    cache_query_if cache_q ();
    tx_req_if      resolver_tx ();
    tx_req_if      reply_tx ();

    // destination MAC is filtered upstream, so frames here are ours
    assign in_frame = '{
        eth_dest_mac: local_mac,
        eth_src_mac:  in_eth_src_mac,
        eth_type:     in_eth_type,
        htype:        in_htype,
        ptype:        in_ptype,
        oper:         arp_pkg::arp_oper_t'(in_oper),
        sha:          in_sha,
        spa:          in_spa,
        tha:          in_tha,
        tpa:          in_tpa
    };

    // queue entry plus our own addresses and the fixed fields
    assign out_frame = '{
        eth_dest_mac: q_dest_mac,
        eth_src_mac:  local_mac,
        eth_type:     `ARP_ETHERTYPE,
        htype:        `ARP_HTYPE_ETH,
        ptype:        `ARP_PTYPE_IPV4,
        oper:         q_oper,
        sha:          local_mac,
        spa:          local_ip,
        tha:          q_tha,
        tpa:          q_tpa
    };

    assign out_eth_dest_mac = out_frame.eth_dest_mac;
    assign out_eth_src_mac = out_frame.eth_src_mac;
    assign out_eth_type = out_frame.eth_type;
    assign out_htype = out_frame.htype;
    assign out_ptype = out_frame.ptype;
    assign out_oper = out_frame.oper;
    assign out_sha = out_frame.sha;
    assign out_spa = out_frame.spa;
    assign out_tha = out_frame.tha;
    assign out_tpa = out_frame.tpa;

    arp_rx_handler rx_handler_i (
        .clk         (clk),
        .rst         (rst),
        .frame       (in_frame),
        .frame_valid (in_valid),
        .frame_ready (in_ready),
        .local_mac   (local_mac),
        .local_ip    (local_ip),
        .wr_valid    (wr_valid),
        .wr_ip       (wr_ip),
        .wr_mac      (wr_mac),
        .tx          (reply_tx)
    );

    arp_resolver resolver_i (
        .clk            (clk),
        .rst            (rst),
        .request_valid  (request_valid),
        .request_ip     (request_ip),
        .response_valid (response_valid),
        .response_error (response_error),
        .response_mac   (response_mac),
        .gateway_ip     (gateway_ip),
        .subnet_mask    (subnet_mask),
        .query          (cache_q),
        .tx             (resolver_tx)
    );

    arp_cache cache_i (
        .clk         (clk),
        .rst         (rst),
        .query       (cache_q),
        .wr_valid    (wr_valid),
        .wr_ip       (wr_ip),
        .wr_mac      (wr_mac),
        .clear_cache (clear_cache)
    );

    arp_tx_queue tx_queue_i (
        .clk         (clk),
        .rst         (rst),
        .req         (resolver_tx),
        .reply       (reply_tx),
        .frame_valid (out_valid),
        .frame_ready (out_ready),
        .dest_mac    (q_dest_mac),
        .oper        (q_oper),
        .tha         (q_tha),
        .tpa         (q_tpa)
    );

endmodule

// ==== src/arp_tx_queue.sv ====
`timescale 1ns/1ps

module arp_tx_queue (
    input  logic               clk,
    input  logic               rst,
    tx_req_if.sink             req,
    tx_req_if.sink             reply,
    output logic               frame_valid,
    input  logic               frame_ready,
    output net_pkg::mac_addr_t dest_mac,
    output arp_pkg::arp_oper_t oper,
    output net_pkg::mac_addr_t tha,
    output net_pkg::ip_addr_t  tpa
);
    logic load_en;

    // slot free now or drained this cycle
    assign load_en = !frame_valid || frame_ready;

    // resolver requests win over replies
    assign req.accept = load_en && req.valid;
    assign reply.accept = load_en && reply.valid && !req.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_valid <= 1'b0;
        end else if (load_en) begin
            frame_valid <= req.valid || reply.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.accept) begin
            dest_mac <= req.dest_mac;
            oper <= req.oper;
            tha <= req.tha;
            tpa <= req.tpa;
        end else if (reply.accept) begin
            dest_mac <= reply.dest_mac;
            oper <= reply.oper;
            tha <= reply.tha;
            tpa <= reply.tpa;
        end
    end

endmodule

// ==== src/net_pkg.sv ====
package net_pkg;

    // ethernet hardware address
    typedef logic [47:0] mac_addr_t;

    // ipv4 protocol address
    typedef logic [31:0] ip_addr_t;

endpackage

// ==== tb/arp_top_tb.sv ====
`timescale 1ns/1ps
`include "arp_defines.svh"

module arp_top_tb;
    localparam int MAX_CYCLES = 6000;
    localparam logic [31:0] LFSR_SEED = 32'habe3_002b;
    localparam logic [15:0] OPER_REQUEST = 16'd1;
    localparam logic [15:0] OPER_REPLY = 16'd2;

    // ARP over Ethernet carrying IPv4
    localparam logic [15:0] ETH_TYPE_ARP = 16'h0806;
    localparam logic [15:0] HW_TYPE_ETH = 16'h0001;
    localparam logic [15:0] PROTO_TYPE_IPV4 = 16'h0800;

    localparam net_pkg::mac_addr_t LOCAL_MAC = 48'h02_00_0a_00_00_05;
    localparam net_pkg::mac_addr_t BCAST_MAC = 48'hffff_ffff_ffff;
    localparam net_pkg::ip_addr_t LOCAL_IP = 32'h0a00_0005;
    localparam net_pkg::ip_addr_t GATEWAY_IP = 32'h0a00_0001;
    localparam net_pkg::ip_addr_t SUBNET_MASK = 32'hffff_ff00;
    // sender IP of the first request frame
    localparam net_pkg::ip_addr_t PEER_IP = 32'h0a00_004d;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    net_pkg::mac_addr_t in_eth_src_mac;
    logic [15:0]        in_eth_type;
    logic [15:0]        in_htype;
    logic [15:0]        in_ptype;
    logic [15:0]        in_oper;
    net_pkg::mac_addr_t in_sha;
    net_pkg::ip_addr_t  in_spa;
    net_pkg::mac_addr_t in_tha;
    net_pkg::ip_addr_t  in_tpa;
    logic               out_valid;
    logic               out_ready;
    net_pkg::mac_addr_t out_eth_dest_mac;
    net_pkg::mac_addr_t out_eth_src_mac;
    logic [15:0]        out_eth_type;
    logic [15:0]        out_htype;
    logic [15:0]        out_ptype;
    logic [15:0]        out_oper;
    net_pkg::mac_addr_t out_sha;
    net_pkg::ip_addr_t  out_spa;
    net_pkg::mac_addr_t out_tha;
    net_pkg::ip_addr_t  out_tpa;
    logic               request_valid;
    net_pkg::ip_addr_t  request_ip;
    logic               response_valid;
    logic               response_error;
    net_pkg::mac_addr_t response_mac;
    net_pkg::mac_addr_t local_mac;
    net_pkg::ip_addr_t  local_ip;
    net_pkg::ip_addr_t  gateway_ip;
    net_pkg::ip_addr_t  subnet_mask;
    logic               clear_cache;

    int                  cycle_count = 0;
    int                  in_taken = 0;
    int                  resp_count = 0;
    net_pkg::mac_addr_t  seen_mac = '0;
    logic                seen_error = 1'b0;
    arp_pkg::arp_frame_t out_log[$];
    logic [31:0]         lfsr_state;

    arp_top arp_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // taps 32 22 2 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic arp_pkg::arp_frame_t current_out_frame();
        arp_pkg::arp_frame_t f;
        f.eth_dest_mac = out_eth_dest_mac;
        f.eth_src_mac = out_eth_src_mac;
        f.eth_type = out_eth_type;
        f.htype = out_htype;
        f.ptype = out_ptype;
        f.oper = arp_pkg::arp_oper_t'(out_oper);
        f.sha = out_sha;
        f.spa = out_spa;
        f.tha = out_tha;
        f.tpa = out_tpa;
        return f;
    endfunction

    task automatic next_mac(output net_pkg::mac_addr_t mac);
        mac = '0;
        for (int i = 0; i < 48; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            mac = {mac[46:0], lfsr_state[0]};
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: time %0t signal %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic verify_frame(input arp_pkg::arp_frame_t f, input net_pkg::mac_addr_t dest,
                                input logic [15:0] oper, input net_pkg::mac_addr_t tha,
                                input net_pkg::ip_addr_t tpa);
        check_value("out_eth_dest_mac", 64'(f.eth_dest_mac), 64'(dest));
        check_value("out_eth_src_mac", 64'(f.eth_src_mac), 64'(LOCAL_MAC));
        check_value("out_eth_type", 64'(f.eth_type), 64'(ETH_TYPE_ARP));
        check_value("out_htype", 64'(f.htype), 64'(HW_TYPE_ETH));
        check_value("out_ptype", 64'(f.ptype), 64'(PROTO_TYPE_IPV4));
        check_value("out_oper", 64'(f.oper), 64'(oper));
        check_value("out_sha", 64'(f.sha), 64'(LOCAL_MAC));
        check_value("out_spa", 64'(f.spa), 64'(LOCAL_IP));
        check_value("out_tha", 64'(f.tha), 64'(tha));
        check_value("out_tpa", 64'(f.tpa), 64'(tpa));
    endtask

    // broadcast who-has frames for one target
    task automatic verify_requests(input int first, input int count, input net_pkg::ip_addr_t ip);
        for (int i = 0; i < count; i++) begin
            verify_frame(out_log[first + i], BCAST_MAC, OPER_REQUEST, 48'h0, ip);
        end
    endtask

    task automatic send_frame(input logic [15:0] eth_type, input logic [15:0] oper,
                              input net_pkg::mac_addr_t sha, input net_pkg::ip_addr_t spa,
                              input net_pkg::mac_addr_t tha, input net_pkg::ip_addr_t tpa);
        int taken_before;
        taken_before = in_taken;
        @(negedge clk);
        in_valid = 1'b1;
        in_eth_src_mac = sha;
        in_eth_type = eth_type;
        in_htype = HW_TYPE_ETH;
        in_ptype = PROTO_TYPE_IPV4;
        in_oper = oper;
        in_sha = sha;
        in_spa = spa;
        in_tha = tha;
        in_tpa = tpa;
        while (in_taken == taken_before) @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic start_lookup(input net_pkg::ip_addr_t ip);
        @(negedge clk);
        request_valid = 1'b1;
        request_ip = ip;
        @(negedge clk);
        request_valid = 1'b0;
    endtask

    task automatic run_lookup(input net_pkg::ip_addr_t ip, output net_pkg::mac_addr_t mac,
                              output logic err, output int frames);
        int resp_before;
        int frames_before;
        resp_before = resp_count;
        frames_before = out_log.size();
        start_lookup(ip);
        while (resp_count == resp_before) @(negedge clk);
        mac = seen_mac;
        err = seen_error;
        frames = out_log.size() - frames_before;
    endtask

    task automatic reply_to_local_request();
        net_pkg::mac_addr_t peer_mac;
        net_pkg::mac_addr_t got_mac;
        logic got_err;
        int frames;
        int logged;
        next_mac(peer_mac);
        out_ready = 1'b0;
        send_frame(ETH_TYPE_ARP, OPER_REQUEST, peer_mac, PEER_IP, 48'h0, LOCAL_IP);
        // reply must sit still while the sink stalls
        repeat (20) begin
            check_value("out_valid", 64'(out_valid), 64'(1'b1));
            verify_frame(current_out_frame(), peer_mac, OPER_REPLY, peer_mac, PEER_IP);
            @(negedge clk);
        end
        logged = out_log.size();
        out_ready = 1'b1;
        while (out_log.size() == logged) @(negedge clk);
        verify_frame(out_log[logged], peer_mac, OPER_REPLY, peer_mac, PEER_IP);
        run_lookup(PEER_IP, got_mac, got_err, frames);
        check_value("response_mac", 64'(got_mac), 64'(peer_mac));
        check_value("response_error", 64'(got_err), 64'(1'b0));
        check_value("frames emitted", 64'(frames), 64'(0));
    endtask

    task automatic ignore_foreign_frames();
        net_pkg::mac_addr_t stray_mac;
        net_pkg::mac_addr_t other_mac;
        net_pkg::mac_addr_t got_mac;
        logic got_err;
        int frames;
        int logged;
        logged = out_log.size();
        next_mac(stray_mac);
        next_mac(other_mac);
        // IPv4 ethertype instead of ARP
        send_frame(16'h0800, OPER_REQUEST, stray_mac, 32'h0a00_0058, 48'h0, LOCAL_IP);
        send_frame(ETH_TYPE_ARP, OPER_REQUEST, other_mac, 32'h0a00_0063, 48'h0, 32'h0a00_0009);
        repeat (10) @(negedge clk);
        check_value("out frame count", 64'(out_log.size()), 64'(logged));
        check_value("out_valid", 64'(out_valid), 64'(1'b0));
        run_lookup(32'h0a00_0058, got_mac, got_err, frames);
        check_value("response_error", 64'(got_err), 64'(1'b1));
        check_value("frames emitted", 64'(frames), 64'(`ARP_RETRY_COUNT));
        verify_requests(out_log.size() - frames, frames, 32'h0a00_0058);
    endtask

    task automatic resolve_broadcast();
        net_pkg::mac_addr_t got_mac;
        logic got_err;
        int frames;
        run_lookup(32'h0a00_00ff, got_mac, got_err, frames);
        check_value("response_mac", 64'(got_mac), 64'(BCAST_MAC));
        check_value("response_error", 64'(got_err), 64'(1'b0));
        check_value("frames emitted", 64'(frames), 64'(0));
    endtask

    task automatic resolve_via_gateway();
        net_pkg::mac_addr_t gw_mac;
        int resp_before;
        int logged;
        next_mac(gw_mac);
        resp_before = resp_count;
        logged = out_log.size();
        start_lookup(32'h0808_0808);
        while (out_log.size() == logged) @(negedge clk);
        verify_frame(out_log[logged], BCAST_MAC, OPER_REQUEST, 48'h0, GATEWAY_IP);
        send_frame(ETH_TYPE_ARP, OPER_REPLY, gw_mac, GATEWAY_IP, LOCAL_MAC, LOCAL_IP);
        while (resp_count == resp_before) @(negedge clk);
        check_value("response_mac", 64'(seen_mac), 64'(gw_mac));
        check_value("response_error", 64'(seen_error), 64'(1'b0));
        check_value("out frame count", 64'(out_log.size()), 64'(logged + 1));
    endtask

    task automatic give_up_unanswered();
        net_pkg::mac_addr_t got_mac;
        logic got_err;
        int frames;
        run_lookup(32'h0a00_00c8, got_mac, got_err, frames);
        check_value("response_error", 64'(got_err), 64'(1'b1));
        check_value("frames emitted", 64'(frames), 64'(`ARP_RETRY_COUNT));
        verify_requests(out_log.size() - frames, frames, 32'h0a00_00c8);
    endtask

    task automatic forget_after_clear();
        net_pkg::mac_addr_t got_mac;
        logic got_err;
        int frames;
        @(negedge clk);
        clear_cache = 1'b1;
        @(negedge clk);
        clear_cache = 1'b0;
        run_lookup(PEER_IP, got_mac, got_err, frames);
        check_value("response_error", 64'(got_err), 64'(1'b1));
        check_value("frames emitted", 64'(frames), 64'(`ARP_RETRY_COUNT));
        verify_requests(out_log.size() - frames, frames, PEER_IP);
    endtask

    // handshakes and pulses seen at the rising edge
    always @(posedge clk) begin
        if (in_valid && in_ready) begin
            in_taken = in_taken + 1;
        end
        if (out_valid && out_ready) begin
            out_log.push_back(current_out_frame());
        end
        if (response_valid) begin
            resp_count = resp_count + 1;
            seen_mac = response_mac;
            seen_error = response_error;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: tests still running after %0d cycles", cycle_count));
        end
    end

    initial begin
        lfsr_state = LFSR_SEED;
        rst = 1'b1;
        in_valid = 1'b0;
        in_eth_src_mac = '0;
        in_eth_type = '0;
        in_htype = '0;
        in_ptype = '0;
        in_oper = '0;
        in_sha = '0;
        in_spa = '0;
        in_tha = '0;
        in_tpa = '0;
        out_ready = 1'b1;
        request_valid = 1'b0;
        request_ip = '0;
        local_mac = LOCAL_MAC;
        local_ip = LOCAL_IP;
        gateway_ip = GATEWAY_IP;
        subnet_mask = SUBNET_MASK;
        clear_cache = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_value("out_valid", 64'(out_valid), 64'(1'b0));
        check_value("response_valid", 64'(response_valid), 64'(1'b0));
        check_value("response_error", 64'(response_error), 64'(1'b0));
        check_value("in_ready", 64'(in_ready), 64'(1'b0));
        reply_to_local_request();
        ignore_foreign_frames();
        resolve_broadcast();
        resolve_via_gateway();
        give_up_unanswered();
        forget_after_clear();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
